//--- hdl/stream_pkg.sv
/* External byte-stream beat shared by both ends of the framer.
   One byte per beat; last marks the final payload byte of a packet. */

`default_nettype none

package stream_pkg;

  //////////////////////////////////////////////////////////////////////
  // Stream beat
  //////////////////////////////////////////////////////////////////////

  localparam int BYTE_W = 8;  // Payload byte width

  // A beat moves on valid and ready, carried next to this struct
  typedef struct packed {
    logic [BYTE_W-1:0] data;  // Byte value
    logic              last;  // Final byte of packet
  } beat_t;

endpackage : stream_pkg

`default_nettype wire

//--- hdl/frame_pkg.sv
/* Internal FIFO word, tagged as payload beat or packet trailer.
   Sum and length wrap at 256; the reserved bits are written as zero. */

`default_nettype none

package frame_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word kind
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    KIND_PAYLOAD = 1'b0,  // Body holds one data byte
    KIND_TRAILER = 1'b1   // Body holds sum and length
  } word_kind_e;

  //////////////////////////////////////////////////////////////////////
  // Body views
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [14:0] rsvd;  // Unused
    logic [7:0]  data;  // Payload byte
  } payload_t;

  typedef struct packed {
    logic [7:0] sum;   // Byte sum mod 256
    logic [7:0] len;   // Byte count mod 256
    logic [6:0] rsvd;  // Unused
  } trailer_t;

  // Same 23 bits read one of two ways, picked by kind
  typedef union packed {
    payload_t payload;
    trailer_t trailer;
  } word_body_u;

  typedef struct packed {
    word_kind_e kind;  // Selects the union view
    word_body_u body;  // 23-bit body
  } fifo_word_t;

endpackage : frame_pkg

`default_nettype wire

//--- hdl/fifo_mem.sv
/* Storage array for the FIFO; write on the clock, read combinationally.
   All entries clear to zero on reset. */

`timescale 1ns/1ps
`default_nettype none

module fifo_mem #(
  parameter int ELEM_WIDTH = 8,  // Bits per entry
  parameter int DEPTH      = 4   // Number of entries
) (
  input  wire logic                         clk_i,    // Clock
  input  wire logic                         rst_n_i,  // Async reset, active low
  input  wire logic                         we_i,     // Write enable
  input  wire logic [$clog2(DEPTH)-1:0]     waddr_i,  // Write address
  input  wire logic [ELEM_WIDTH-1:0]        wdata_i,  // Write data
  input  wire logic [$clog2(DEPTH)-1:0]     raddr_i,  // Read address
  output logic      [ELEM_WIDTH-1:0]        rdata_o   // Read data
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  logic [ELEM_WIDTH-1:0] mem_q [DEPTH];  // Entry array

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;  // Clear every entry
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;  // One write per cycle
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  assign rdata_o = mem_q[raddr_i];  // No read latency

endmodule : fifo_mem

`default_nettype wire

//--- hdl/fifo.sv
/* Valid/ready FIFO of 2**FIFO_SIZE entries; FIFO_SIZE must be 1 or more.
   PIPELINED=0 lets a word pass through in the same cycle when empty. */

`timescale 1ns/1ps
`default_nettype none

module fifo #(
  parameter bit PIPELINED  = 1,  // 1 registers the output path
  parameter int ELEM_WIDTH = 8,  // Bits per element
  parameter int FIFO_SIZE  = 2   // Log2 of the depth
) (
  input  wire logic                  clk_i,             // Clock
  input  wire logic                  rst_n_i,           // Async reset, active low

  input  wire logic [ELEM_WIDTH-1:0] elem_in_i,         // Write side element
  input  wire logic                  elem_in_valid_i,   // Write side valid
  output logic                       elem_in_ready_o,   // Write side ready

  output logic      [ELEM_WIDTH-1:0] elem_out_o,        // Read side element
  output logic                       elem_out_valid_o,  // Read side valid
  input  wire logic                  elem_out_ready_i   // Read side ready
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic [FIFO_SIZE:0]    wr_ptr_q;  // Write pointer with wrap bit
  logic [FIFO_SIZE:0]    rd_ptr_q;  // Read pointer with wrap bit
  logic                  push;      // Write handshake
  logic                  pop;       // Read handshake
  logic                  wrap_eq;   // Wrap bits match
  logic                  addr_eq;   // Index bits match
  logic                  empty;
  logic                  full;
  logic [ELEM_WIDTH-1:0] mem_rdata;  // Head entry

  //////////////////////////////////////////////////////////////////////
  // Status and handshakes
  //////////////////////////////////////////////////////////////////////

  assign push = elem_in_valid_i & elem_in_ready_o;
  assign pop  = elem_out_valid_o & elem_out_ready_i;

  assign wrap_eq = (wr_ptr_q[FIFO_SIZE] == rd_ptr_q[FIFO_SIZE]);
  assign addr_eq = (wr_ptr_q[FIFO_SIZE-1:0] == rd_ptr_q[FIFO_SIZE-1:0]);
  assign empty   = wrap_eq & addr_eq;
  assign full    = ~wrap_eq & addr_eq;  // Same slot, one lap apart

  // When full, a write is taken only alongside a read
  assign elem_in_ready_o = full ? elem_out_ready_i : 1'b1;

  if (PIPELINED) begin : g_pipelined
    assign elem_out_valid_o = ~empty;
    assign elem_out_o       = mem_rdata;
  end else begin : g_pass_through
    assign elem_out_valid_o = empty ? elem_in_valid_i : 1'b1;  // Bypass when empty
    assign elem_out_o       = empty ? elem_in_i : mem_rdata;
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps into the lap bit
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  fifo_mem #(
    .ELEM_WIDTH (ELEM_WIDTH),
    .DEPTH      (2 ** FIFO_SIZE)
  ) u_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .we_i    (push),
    .waddr_i (wr_ptr_q[FIFO_SIZE-1:0]),
    .wdata_i (elem_in_i),
    .raddr_i (rd_ptr_q[FIFO_SIZE-1:0]),
    .rdata_o (mem_rdata)
  );

endmodule : fifo

`default_nettype wire

//--- hdl/frame_ingress.sv
/* Packs input beats into FIFO words and appends one trailer per packet.
   Input stalls at least one cycle per trailer; counts wrap past 255. */

`timescale 1ns/1ps
`default_nettype none

module frame_ingress (
  input  wire logic                 clk_i,         // Clock
  input  wire logic                 rst_n_i,       // Async reset, active low

  input  wire stream_pkg::beat_t    in_beat_i,     // Input beat
  input  wire logic                 in_valid_i,    // Input valid
  output logic                      in_ready_o,    // Input ready

  output frame_pkg::fifo_word_t     word_o,        // Word to FIFO
  output logic                      word_valid_o,  // Word valid
  input  wire logic                 word_ready_i   // FIFO ready
);

  import frame_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic       trailer_q;  // Trailer pending
  logic [7:0] sum_q;      // Running byte sum
  logic [7:0] len_q;      // Running byte count
  logic       beat_hs;    // Input beat accepted
  logic       trailer_hs; // Trailer taken by FIFO
  payload_t   payload;
  trailer_t   trailer;

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  // Input follows the FIFO except while the trailer is out
  assign in_ready_o   = word_ready_i & ~trailer_q;
  assign word_valid_o = trailer_q | in_valid_i;

  assign beat_hs    = in_valid_i & in_ready_o;
  assign trailer_hs = trailer_q & word_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Word build
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    payload      = '0;
    payload.data = in_beat_i.data;  // Byte passes unchanged

    trailer      = '0;
    trailer.sum  = sum_q;
    trailer.len  = len_q;

    if (trailer_q) begin
      word_o.kind         = KIND_TRAILER;
      word_o.body.trailer = trailer;
    end else begin
      word_o.kind         = KIND_PAYLOAD;
      word_o.body.payload = payload;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulators and trailer state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trailer_q <= 1'b0;
      sum_q     <= '0;
      len_q     <= '0;
    end else if (trailer_hs) begin
      trailer_q <= 1'b0;  // Trailer sent, start next packet
      sum_q     <= '0;
      len_q     <= '0;
    end else if (beat_hs) begin
      sum_q <= sum_q + in_beat_i.data;  // Mod 256
      len_q <= len_q + 8'd1;
      if (in_beat_i.last) begin
        trailer_q <= 1'b1;  // Totals now hold the whole packet
      end
    end
  end

endmodule : frame_ingress

`default_nettype wire

//--- hdl/frame_egress.sv
/* Turns FIFO words back into bytes; a trailer goes out as sum then length.
   The word is popped with its last byte, so the FIFO head stays put meanwhile. */

`timescale 1ns/1ps
`default_nettype none

module frame_egress (
  input  wire logic                  clk_i,         // Clock
  input  wire logic                  rst_n_i,       // Async reset, active low

  input  wire frame_pkg::fifo_word_t word_i,        // Head of FIFO
  input  wire logic                  word_valid_i,  // Head valid
  output logic                       word_ready_o,  // Pop request

  output stream_pkg::beat_t          out_beat_o,    // Output beat
  output logic                       out_valid_o,   // Output valid
  input  wire logic                  out_ready_i    // Output ready
);

  import frame_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic phase_q;     // 0 sum byte, 1 length byte
  logic is_trailer;  // Head is a trailer word
  logic out_hs;      // Output byte accepted

  assign is_trailer = (word_i.kind == KIND_TRAILER);
  assign out_hs     = out_valid_o & out_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Output decode
  //////////////////////////////////////////////////////////////////////

  assign out_valid_o = word_valid_i;  // Every word gives at least one byte

  always_comb begin
    if (!is_trailer) begin
      out_beat_o.data = word_i.body.payload.data;
      out_beat_o.last = 1'b0;  // Last rides on the length byte
    end else if (phase_q) begin
      out_beat_o.data = word_i.body.trailer.len;
      out_beat_o.last = 1'b1;
    end else begin
      out_beat_o.data = word_i.body.trailer.sum;
      out_beat_o.last = 1'b0;
    end
  end

  // Pop on the final byte of the word only
  assign word_ready_o = out_ready_i & (~is_trailer | phase_q);

  //////////////////////////////////////////////////////////////////////
  // Trailer phase
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= 1'b0;
    end else if (out_hs && is_trailer) begin
      phase_q <= ~phase_q;  // Sum then length, back to sum
    end
  end

endmodule : frame_egress

`default_nettype wire

//--- hdl/frame_buffer_top.sv
/* Byte-stream framer; ingress adds trailers, FIFO decouples, egress expands.
   FIFO_SIZE must be at least 1. */

`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top #(
  parameter int FIFO_SIZE = 2,  // Log2 of FIFO depth
  parameter bit PIPELINED = 1   // 0 allows FIFO pass-through
) (
  input  wire logic              clk_i,        // Clock
  input  wire logic              rst_n_i,      // Async reset, active low

  input  wire stream_pkg::beat_t in_beat_i,    // Payload in
  input  wire logic              in_valid_i,
  output logic                   in_ready_o,

  output stream_pkg::beat_t      out_beat_o,   // Framed bytes out
  output logic                   out_valid_o,
  input  wire logic              out_ready_i
);

  import frame_pkg::*;

  localparam int ELEM_WIDTH = $bits(fifo_word_t);  // FIFO word width

  //////////////////////////////////////////////////////////////////////
  // Internal streams
  //////////////////////////////////////////////////////////////////////

  fifo_word_t ing_word;        // Ingress to FIFO
  logic       ing_word_valid;
  logic       ing_word_ready;
  fifo_word_t egr_word;        // FIFO to egress
  logic       egr_word_valid;
  logic       egr_word_ready;

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  frame_ingress u_ingress (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_beat_i    (in_beat_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .word_o       (ing_word),
    .word_valid_o (ing_word_valid),
    .word_ready_i (ing_word_ready)
  );

  fifo #(
    .PIPELINED  (PIPELINED),
    .ELEM_WIDTH (ELEM_WIDTH),
    .FIFO_SIZE  (FIFO_SIZE)
  ) u_fifo (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .elem_in_i        (ing_word),
    .elem_in_valid_i  (ing_word_valid),
    .elem_in_ready_o  (ing_word_ready),
    .elem_out_o       (egr_word),
    .elem_out_valid_o (egr_word_valid),
    .elem_out_ready_i (egr_word_ready)
  );

  frame_egress u_egress (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .word_i       (egr_word),
    .word_valid_i (egr_word_valid),
    .word_ready_o (egr_word_ready),
    .out_beat_o   (out_beat_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i)
  );

endmodule : frame_buffer_top

`default_nettype wire

//--- tests/tb_frame_buffer.sv
/* Directed testbench for the framer; a byte queue models the expected output.
   Inputs change 1 ns after the rising edge; outputs are sampled on the edge. */

`timescale 1ns/1ps
`default_nettype none

module tb_frame_buffer;

  import stream_pkg::*;

  localparam int TIMEOUT_CYCLES = 500;  // Per wait loop
  localparam int READY_HIGH     = 0;
  localparam int READY_RANDOM   = 1;
  localparam int READY_LOW      = 2;

  logic        clk;
  logic        rst_n_i;
  beat_t       in_beat_i;
  logic        in_valid_i;
  logic        in_ready_o;
  beat_t       out_beat_o;
  logic        out_valid_o;
  logic        out_ready_i;

  beat_t       expect_q[$];     // Reference model
  beat_t       exp_beat;        // Head popped by the monitor
  string       current_test;
  int          ready_mode;      // Output ready pattern
  logic [31:0] rng_state;       // Stimulus data and lengths
  logic [31:0] ready_rng;       // Output ready pattern

  frame_buffer_top #(
    .FIFO_SIZE (2),
    .PIPELINED (1)
  ) dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n_i),
    .in_beat_i   (in_beat_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_beat_o  (out_beat_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: test %s expected %h actual %h", name, expected, actual);
      abort_run("Value mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, output ready and monitor
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  always @(posedge clk) begin
    #1;
    case (ready_mode)
      READY_HIGH: out_ready_i = 1'b1;
      READY_RANDOM: begin
        ready_rng   = xorshift32(ready_rng);
        out_ready_i = ready_rng[0];  // About half the cycles
      end
      default: out_ready_i = 1'b0;
    endcase
  end

  // Every output transfer must match the model head
  always @(posedge clk) begin
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (expect_q.size() == 0) begin
        abort_run("Output byte arrived when no byte was expected");
      end else begin
        exp_beat = expect_q.pop_front();
        check_value(current_test, 32'(exp_beat), 32'(out_beat_o));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // Called 1 ns after an edge; returns 1 ns after the accepting edge
  task automatic send_beat(input logic [7:0] data, input logic last);
    int    waited;
    logic  taken;
    beat_t b;
    waited          = 0;
    taken           = 1'b0;
    in_beat_i.data  = data;
    in_beat_i.last  = last;
    in_valid_i      = 1'b1;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready_o;  // Stable until the next edge
      if (taken) begin
        b.data = data;
        b.last = 1'b0;     // Payload leaves with last clear
        expect_q.push_back(b);
      end
      @(posedge clk);
      #1;
      waited++;
      if (!taken && waited >= TIMEOUT_CYCLES) begin
        abort_run("Input beat was not accepted before the timeout");
      end
    end
    in_valid_i = 1'b0;
  endtask

  task automatic send_packet(input int len);
    logic [7:0] sum;
    logic [7:0] data;
    beat_t      b;
    sum = 8'd0;
    for (int i = 0; i < len; i++) begin
      rng_state = xorshift32(rng_state);
      data      = rng_state[7:0];
      sum       = sum + data;  // Wraps at 256
      send_beat(data, (i == len - 1));
    end
    b.data = sum;
    b.last = 1'b0;
    expect_q.push_back(b);
    b.data = 8'(len);
    b.last = 1'b1;  // Length byte closes the packet
    expect_q.push_back(b);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expect_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited >= TIMEOUT_CYCLES) begin
        abort_run("Expected output bytes did not arrive before the timeout");
      end
    end
    @(negedge clk);
    check_value({current_test, " idle"}, 32'd0, 32'(out_valid_o));
    @(posedge clk);
    #1;
  endtask

  task automatic wait_input_stall();
    int waited;
    waited = 0;
    forever begin
      @(negedge clk);
      if (in_valid_i && !in_ready_o) break;  // FIFO full, input held off
      waited++;
      if (waited >= TIMEOUT_CYCLES) begin
        abort_run("Input ready never dropped while the output was stalled");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    current_test = "reset";
    @(negedge clk);
    check_value("reset out_valid", 32'd0, 32'(out_valid_o));
    check_value("reset in_ready", 32'd1, 32'(in_ready_o));
    @(posedge clk);
    #1;
  endtask

  task automatic single_packet();
    current_test = "single packet";
    ready_mode   = READY_HIGH;
    send_packet(5);
    wait_drain();
  endtask

  task automatic back_to_back_packets();
    current_test = "back to back";
    ready_mode   = READY_HIGH;
    for (int p = 0; p < 6; p++) begin
      rng_state = xorshift32(rng_state);
      send_packet(1 + int'(rng_state % 20));  // 1 to 20 bytes
    end
    wait_drain();
  endtask

  task automatic random_output_ready();
    current_test = "random ready";
    ready_mode   = READY_RANDOM;
    for (int p = 0; p < 8; p++) begin
      rng_state = xorshift32(rng_state);
      send_packet(1 + int'(rng_state % 20));
    end
    ready_mode = READY_HIGH;
    wait_drain();
  endtask

  task automatic output_backpressure();
    current_test = "backpressure";
    ready_mode   = READY_LOW;
    fork
      send_packet(12);
      begin
        wait_input_stall();
        repeat (5) @(posedge clk);  // Hold the stall a little longer
        ready_mode = READY_HIGH;
      end
    join
    wait_drain();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i      = 1'b0;
    in_beat_i    = '0;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b1;
    ready_mode   = READY_HIGH;
    current_test = "init";
    rng_state    = 32'hf932_fd58;
    ready_rng    = xorshift32(32'hf932_fd58);  // Separate stream for ready
    repeat (8) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    reset_state();
    single_packet();
    back_to_back_packets();
    random_output_ready();
    output_backpressure();

    $display("All tests passed");
    $finish;
  end

endmodule : tb_frame_buffer

`default_nettype wire

//--- vlog.f
hdl/stream_pkg.sv
hdl/frame_pkg.sv
hdl/fifo_mem.sv
hdl/fifo.sv
hdl/frame_ingress.sv
hdl/frame_egress.sv
hdl/frame_buffer_top.sv
tests/tb_frame_buffer.sv

//--- Makefile
# Verilator build for the byte-stream framer testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_frame_buffer
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Some tests failed

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
